//--- source/arcade_input_pkg.sv
/*
  Shared types and constants for the arcade player input path
  Port bytes are active low, a set bit means the input is idle
  Download indexes are defaults only and the top level may override them
*/
package arcade_input_pkg;

	// ==============================
	// Game variants and port types
	// ==============================

	// Codes as sent over the download port
	typedef enum logic [7:0] {
		gv_scramble = 8'd0,
		gv_tazman   = 8'd4,
		gv_losttomb = 8'd11,
		gv_stratgyx = 8'd14,
		gv_minefld  = 8'd16
	} game_variant_e;

	typedef logic [7:0]  hw_sel_t;     // Board hardware select code
	typedef logic [7:0]  port_byte_t;  // One active-low input port
	typedef logic [31:0] joy_word_t;   // Host joystick word
	typedef logic [15:0] key_btn_t;    // Held keyboard buttons

	// Bit positions in key_btn_t
	typedef enum logic [3:0] {
		kb_up,
		kb_down,
		kb_left,
		kb_right,
		kb_fire1,
		kb_fire2,
		kb_start1,
		kb_start2,
		kb_coin1,
		kb_coin2,
		kb_up2,
		kb_down2,
		kb_left2,
		kb_right2,
		kb_fire1_2,
		kb_fire2_2
	} key_btn_e;

	// ==============================
	// Joystick word layout
	// ==============================
	localparam int JB_RIGHT  = 0;
	localparam int JB_LEFT   = 1;
	localparam int JB_DOWN   = 2;
	localparam int JB_UP     = 3;
	localparam int JB_FIRE_A = 4;
	localparam int JB_FIRE_B = 5;
	localparam int JB_FIRE_C = 6;
	localparam int JB_FIRE_D = 7;
	localparam int JB_FIRE_E = 8;
	localparam int JB_START1 = 8;   // Shares the fire e bit
	localparam int JB_START2 = 9;
	localparam int JB_COIN   = 10;

	// Default download indexes
	localparam logic [7:0] DL_INDEX_VARIANT = 8'd1;
	localparam logic [7:0] DL_INDEX_DIP     = 8'd254;

endpackage

//--- source/kbd_decode.sv
/*
  Keyboard scancode decoder, holds one bit per mapped button
  Expects the host event word where bit 10 toggles once per event
  Arrow codes match with or without the extended prefix, others only without
*/
module kbd_decode
	import arcade_input_pkg::*;
(
	input  logic        clk_sys,
	input  logic        rst_n,
	input  logic [10:0] ps2_key,
	output key_btn_t    key_btn
);

	logic       toggle_q;   // Last sampled event toggle
	logic       pressed;
	logic [8:0] code;       // Bit 8 is the extended flag
	logic       key_hit;
	key_btn_e   key_idx;

	assign pressed = ps2_key[9];
	assign code    = ps2_key[8:0];

	// Scancode to button position
	always_comb
	begin
		key_hit = 1'b1;
		key_idx = kb_up;
		casez (code)
			9'b?0111_0101: key_idx = kb_up;
			9'b?0111_0010: key_idx = kb_down;
			9'b?0110_1011: key_idx = kb_left;
			9'b?0111_0100: key_idx = kb_right;
			9'h014:        key_idx = kb_fire1;     // Ctrl
			9'h029:        key_idx = kb_fire2;     // Space
			9'h005:        key_idx = kb_start1;    // F1
			9'h006:        key_idx = kb_start2;    // F2

			// Cabinet style layout
			9'h016:        key_idx = kb_start1;    // 1
			9'h01E:        key_idx = kb_start2;    // 2
			9'h02E:        key_idx = kb_coin1;     // 5
			9'h036:        key_idx = kb_coin2;     // 6
			9'h02D:        key_idx = kb_up2;       // R
			9'h02B:        key_idx = kb_down2;     // F
			9'h023:        key_idx = kb_left2;     // D
			9'h034:        key_idx = kb_right2;    // G
			9'h01C:        key_idx = kb_fire1_2;   // A
			9'h01B:        key_idx = kb_fire2_2;   // S
			default:       key_hit = 1'b0;
		endcase
	end

	always_ff @(posedge clk_sys)
	begin
		toggle_q <= ps2_key[10];
		if (!rst_n)
		begin
			key_btn <= '0;
		end
		else if ((toggle_q != ps2_key[10]) && key_hit)
		begin
			key_btn[key_idx] <= pressed;
		end
	end

endmodule

//--- source/game_select.sv
/*
  Game variant register loaded from the host download port
  Codes other than the five kept variants fall back to scramble
  Outputs change on the edge that accepts the write
*/
module game_select
	import arcade_input_pkg::*;
#(
	parameter logic [7:0] VARIANT_INDEX = DL_INDEX_VARIANT
)
(
	input  logic          clk_sys,
	input  logic          rst_n,
	input  logic          dl_wr,
	input  logic [7:0]    dl_index,
	input  logic [7:0]    dl_data,
	output game_variant_e variant,
	output hw_sel_t       hw_sel,
	output logic          landscape,
	output logic          four_fire
);

	game_variant_e code_variant;    // Download byte as a kept variant
	hw_sel_t       next_hw_sel;
	logic          next_landscape;
	logic          next_four_fire;

	always_comb
	begin
		case (dl_data)
			gv_tazman:   code_variant = gv_tazman;
			gv_losttomb: code_variant = gv_losttomb;
			gv_stratgyx: code_variant = gv_stratgyx;
			gv_minefld:  code_variant = gv_minefld;
			default:     code_variant = gv_scramble;
		endcase
	end

	// Board settings per variant
	always_comb
	begin
		next_hw_sel    = 8'd0;
		next_landscape = 1'b0;
		next_four_fire = 1'b0;
		case (code_variant)
			gv_tazman:
			begin
				next_hw_sel = 8'd2;
			end
			gv_losttomb:
			begin
				next_hw_sel    = 8'd7;
				next_four_fire = 1'b1;
			end
			gv_minefld:
			begin
				next_hw_sel    = 8'd8;
				next_four_fire = 1'b1;
			end
			gv_stratgyx:
			begin
				next_hw_sel    = 8'd5;
				next_landscape = 1'b1;   // Horizontal monitor
			end
			default:;
		endcase
	end

	always_ff @(posedge clk_sys)
	begin
		if (!rst_n)
		begin
			variant   <= gv_scramble;
			hw_sel    <= '0;
			landscape <= 1'b0;
			four_fire <= 1'b0;
		end
		else if (dl_wr && (dl_index == VARIANT_INDEX))
		begin
			variant   <= code_variant;
			hw_sel    <= next_hw_sel;
			landscape <= next_landscape;
			four_fire <= next_four_fire;
		end
	end

endmodule

//--- source/port_mapper.sv
/*
  Merges held keys with both joysticks and packs the four input ports
  Player 1 and player 2 controls are ORed together, the board sees one set
  Outputs are active low and registered, raw_d is tied idle
*/
module port_mapper
	import arcade_input_pkg::*;
(
	input  logic          clk_sys,
	input  logic          rst_n,
	input  key_btn_t      key_btn,
	input  joy_word_t     joy1,
	input  joy_word_t     joy2,
	input  logic          alt_controls,   // Move with the fire block
	input  game_variant_e variant,
	output port_byte_t    raw_a,
	output port_byte_t    raw_b,
	output port_byte_t    raw_c,
	output port_byte_t    raw_d
);

	joy_word_t  joy_any;
	logic       m_up;
	logic       m_down;
	logic       m_left;
	logic       m_right;
	logic       m_fire_a;
	logic       m_fire_b;
	logic       m_fire_c;
	logic       m_fire_d;
	logic       m_fire_e;
	logic       m_start1;
	logic       m_start2;
	logic       m_coin;
	port_byte_t next_a;
	port_byte_t next_b;
	port_byte_t next_c;

	// ==============================
	// Control merge
	// ==============================
	assign joy_any = joy1 | joy2;

	assign m_up     = key_btn[kb_up]    | key_btn[kb_up2]    | joy_any[JB_UP];
	assign m_down   = key_btn[kb_down]  | key_btn[kb_down2]  | joy_any[JB_DOWN];
	assign m_left   = key_btn[kb_left]  | key_btn[kb_left2]  | joy_any[JB_LEFT];
	assign m_right  = key_btn[kb_right] | key_btn[kb_right2] | joy_any[JB_RIGHT];
	assign m_fire_a = key_btn[kb_fire1] | key_btn[kb_fire1_2] | joy_any[JB_FIRE_A];
	assign m_fire_b = key_btn[kb_fire2] | key_btn[kb_fire2_2] | joy_any[JB_FIRE_B];
	assign m_fire_c = joy_any[JB_FIRE_C];   // Joystick only
	assign m_fire_d = joy_any[JB_FIRE_D];
	assign m_fire_e = joy_any[JB_FIRE_E];

	assign m_start1 = key_btn[kb_start1] | joy_any[JB_START1];
	assign m_start2 = key_btn[kb_start2] | joy_any[JB_START2];
	assign m_coin   = key_btn[kb_coin1]  | key_btn[kb_coin2] | joy_any[JB_COIN];

	// No inputs on this port in any variant
	assign raw_d = 8'hFF;

	// ==============================
	// Port layout per variant
	// ==============================
	always_comb
	begin
		// Scramble layout unless the variant says otherwise
		next_a = ~{m_coin, 1'b0, m_left, m_right, m_fire_a, 1'b0, m_fire_b, m_up};
		next_b = ~{m_start1, m_start2, m_left, m_right, m_fire_a, m_fire_b, 2'b00};
		next_c = ~{1'b0, m_down, 1'b0, m_up, 3'b000, m_down};

		case (variant)
			gv_stratgyx:
			begin
				next_c = ~{m_fire_c, m_down, m_fire_c, m_up, 3'b000, m_down};
			end
			gv_tazman:
			begin
				next_a = ~{m_coin, 1'b0, m_left, m_right, m_down, m_up, m_fire_a, m_fire_b};
				next_b = 8'hFF;
				next_c = ~{1'b0, m_start2, 5'b00000, m_start1};
			end
			gv_losttomb:
			begin
				next_a = ~{m_coin, 1'b0, m_left, m_right, m_down, m_up, m_start1, m_start2};
				if (alt_controls)
					next_b = ~{1'b0, m_fire_e | m_fire_a, m_left, m_right, m_down, m_up, 2'b00};
				else
					next_b = ~{1'b0, m_fire_e, m_fire_d, m_fire_a, m_fire_b, m_fire_c, 2'b00};
				next_c = 8'hFF;
			end
			gv_minefld:
			begin
				next_a = ~{m_coin, 1'b0, m_left, m_right, m_down, m_up, 1'b0, m_start1};
				if (alt_controls)
					next_b = ~{2'b00, m_left, m_right, m_down, m_up, 2'b00};
				else
					next_b = ~{2'b00, m_fire_d, m_fire_a, m_fire_b, m_fire_c, 2'b00};
				next_c = ~{1'b0, m_start2, 5'b00000, m_start1};   // Same as tazman
			end
			default:;
		endcase
	end

	always_ff @(posedge clk_sys)
	begin
		if (!rst_n)
		begin
			raw_a <= 8'hFF;
			raw_b <= 8'hFF;
			raw_c <= 8'hFF;
		end
		else
		begin
			raw_a <= next_a;
			raw_b <= next_b;
			raw_c <= next_c;
		end
	end

endmodule

//--- source/dip_mask.sv
/*
  DIP switch bank loaded over the download port, masks the raw port bytes
  Only addresses 0 to 3 at the DIP index are stored, the rest are dropped
  A cleared DIP bit forces that port bit active
*/
module dip_mask
	import arcade_input_pkg::*;
#(
	parameter logic [7:0] DIP_INDEX = DL_INDEX_DIP
)
(
	input  logic        clk_sys,
	input  logic        rst_n,
	input  logic        dl_wr,
	input  logic [7:0]  dl_index,
	input  logic [15:0] dl_addr,
	input  logic [7:0]  dl_data,
	input  port_byte_t  raw_a,
	input  port_byte_t  raw_b,
	input  port_byte_t  raw_c,
	input  port_byte_t  raw_d,
	output port_byte_t  port_a,
	output port_byte_t  port_b,
	output port_byte_t  port_c,
	output port_byte_t  port_d
);

	port_byte_t dip [4];   // One byte per port
	logic       dip_wr;

	assign dip_wr = dl_wr && (dl_index == DIP_INDEX) && (dl_addr[15:2] == 14'd0);

	always_ff @(posedge clk_sys)
	begin
		if (!rst_n)
		begin
			dip    <= '{default: 8'hFF};   // Pass everything through
			port_a <= 8'hFF;
			port_b <= 8'hFF;
			port_c <= 8'hFF;
			port_d <= 8'hFF;
		end
		else
		begin
			if (dip_wr)
				dip[dl_addr[1:0]] <= dl_data;

			// Masked with the DIP bytes held before this write
			port_a <= dip[0] & raw_a;
			port_b <= dip[1] & raw_b;
			port_c <= dip[2] & raw_c;
			port_d <= dip[3] & raw_d;
		end
	end

endmodule

//--- source/input_top.sv
/*
  Player input path of the arcade board, keys and joysticks to port bytes
  Key events reach the ports in three cycles, joysticks in two
*/
module input_top
	import arcade_input_pkg::*;
#(
	parameter logic [7:0] VARIANT_INDEX = DL_INDEX_VARIANT,
	parameter logic [7:0] DIP_INDEX     = DL_INDEX_DIP
)
(
	input  logic        clk_sys,
	input  logic        rst_n,
	input  logic [10:0] ps2_key,
	input  joy_word_t   joy1,
	input  joy_word_t   joy2,
	input  logic        alt_controls,
	input  logic        dl_wr,
	input  logic [7:0]  dl_index,
	input  logic [15:0] dl_addr,
	input  logic [7:0]  dl_data,
	output port_byte_t  port_a,
	output port_byte_t  port_b,
	output port_byte_t  port_c,
	output port_byte_t  port_d,
	output hw_sel_t     hw_sel,
	output logic        landscape,
	output logic        four_fire
);

	key_btn_t      key_btn;
	game_variant_e variant;
	port_byte_t    raw_a;
	port_byte_t    raw_b;
	port_byte_t    raw_c;
	port_byte_t    raw_d;

	kbd_decode i_kbd_decode (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.ps2_key (ps2_key),
		.key_btn (key_btn)
	);

	game_select #(.VARIANT_INDEX(VARIANT_INDEX)) i_game_select (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.dl_wr     (dl_wr),
		.dl_index  (dl_index),
		.dl_data   (dl_data),
		.variant   (variant),
		.hw_sel    (hw_sel),
		.landscape (landscape),
		.four_fire (four_fire)
	);

	port_mapper i_port_mapper (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.key_btn      (key_btn),
		.joy1         (joy1),
		.joy2         (joy2),
		.alt_controls (alt_controls),
		.variant      (variant),
		.raw_a        (raw_a),
		.raw_b        (raw_b),
		.raw_c        (raw_c),
		.raw_d        (raw_d)
	);

	dip_mask #(.DIP_INDEX(DIP_INDEX)) i_dip_mask (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.dl_wr    (dl_wr),
		.dl_index (dl_index),
		.dl_addr  (dl_addr),
		.dl_data  (dl_data),
		.raw_a    (raw_a),
		.raw_b    (raw_b),
		.raw_c    (raw_c),
		.raw_d    (raw_d),
		.port_a   (port_a),
		.port_b   (port_b),
		.port_c   (port_c),
		.port_d   (port_d)
	);

endmodule

//--- dv/tb_vectors.svh
/*
  Columns: action, op_a, op_b, op_c, then expected port_a to port_d,
  hw_sel, landscape and four_fire. Key op_a is {press, extended, code}
*/
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

task automatic load_vectors();
	add_row(act_idle, 0, 0, 0, 'hFF, 'hFF, 'hFF, 'hFF, 0, 0, 0);       // Reset state

	// ==============================
	// Keyboard under scramble
	// ==============================
	add_row(act_key, 'h275, 0, 0, 'hFE, 'hFF, 'hEF, 'hFF, 0, 0, 0);
	add_row(act_key, 'h175, 0, 0, 'hFF, 'hFF, 'hFF, 'hFF, 0, 0, 0);    // Release with prefix
	add_row(act_key, 'h36B, 0, 0, 'hDF, 'hDF, 'hFF, 'hFF, 0, 0, 0);
	add_row(act_key, 'h214, 0, 0, 'hD7, 'hD7, 'hFF, 'hFF, 0, 0, 0);
	add_row(act_key, 'h329, 0, 0, 'hD7, 'hD7, 'hFF, 'hFF, 0, 0, 0);    // Space with prefix
	add_row(act_key, 'h21A, 0, 0, 'hD7, 'hD7, 'hFF, 'hFF, 0, 0, 0);    // Unmapped
	add_row(act_key, 'h06B, 0, 0, 'hF7, 'hF7, 'hFF, 'hFF, 0, 0, 0);
	add_row(act_key, 'h014, 0, 0, 'hFF, 'hFF, 'hFF, 'hFF, 0, 0, 0);
	add_row(act_key, 'h22E, 0, 0, 'h7F, 'hFF, 'hFF, 'hFF, 0, 0, 0);
	add_row(act_key, 'h206, 0, 0, 'h7F, 'hBF, 'hFF, 'hFF, 0, 0, 0);
	add_row(act_key, 'h22B, 0, 0, 'h7F, 'hBF, 'hBE, 'hFF, 0, 0, 0);

	// Coin 1, start 2 and player 2 down still held
	add_row(act_rand, 0, 0, 'h0980, 0, 0, 0, 0, 0, 0, 0);
	add_row(act_rand, 0, 0, 'h0980, 0, 0, 0, 0, 0, 0, 0);
	add_row(act_joy, 0, 0, 0, 'h7F, 'hBF, 'hBE, 'hFF, 0, 0, 0);
	add_row(act_key, 'h02E, 0, 0, 'hFF, 'hBF, 'hBE, 'hFF, 0, 0, 0);
	add_row(act_key, 'h006, 0, 0, 'hFF, 'hFF, 'hBE, 'hFF, 0, 0, 0);
	add_row(act_key, 'h02B, 0, 0, 'hFF, 'hFF, 'hFF, 'hFF, 0, 0, 0);

	// Nothing held, every joystick bit shows
	add_row(act_rand, 0, 0, 'h0000, 0, 0, 0, 0, 0, 0, 0);
	add_row(act_rand, 0, 0, 'h0000, 0, 0, 0, 0, 0, 0, 0);
	add_row(act_joy, 'h100, 'h400, 0, 'h7F, 'h7F, 'hFF, 'hFF, 0, 0, 0);  // Start 1 and coin
	add_row(act_joy, 'h200, 0, 0, 'hFF, 'hBF, 'hFF, 'hFF, 0, 0, 0);

	// ==============================
	// Variants
	// ==============================
	// Set A gives up, left, fire a, c, e and coin
	// Set B gives right, down, fire b, d and start 2
	add_row(act_joy, 'h118, 'h442, 0, 'h56, 'h57, 'hEF, 'hFF, 0, 0, 0);
	add_row(act_variant, 'h04, 'h01, 0, 'h59, 'hFF, 'hFE, 'hFF, 2, 0, 0);
	add_row(act_joy, 'h118, 'h442, 1, 'h59, 'hFF, 'hFE, 'hFF, 2, 0, 0);
	add_row(act_joy, 'h0A1, 'h204, 1, 'hE6, 'hFF, 'hBF, 'hFF, 2, 0, 0);
	add_row(act_variant, 'h0B, 'h01, 0, 'hE6, 'hE7, 'hFF, 'hFF, 7, 0, 1);
	add_row(act_joy, 'h0A1, 'h204, 0, 'hE6, 'hD7, 'hFF, 'hFF, 7, 0, 1);
	add_row(act_joy, 'h118, 'h442, 0, 'h59, 'hAB, 'hFF, 'hFF, 7, 0, 1);
	add_row(act_joy, 'h118, 'h442, 1, 'h59, 'h9B, 'hFF, 'hFF, 7, 0, 1);
	add_row(act_variant, 'h10, 'h01, 0, 'h5A, 'hDB, 'hFE, 'hFF, 8, 0, 1);
	add_row(act_joy, 'h118, 'h442, 0, 'h5A, 'hEB, 'hFE, 'hFF, 8, 0, 1);
	add_row(act_joy, 'h0A1, 'h204, 0, 'hE7, 'hD7, 'hBF, 'hFF, 8, 0, 1);
	add_row(act_joy, 'h0A1, 'h204, 1, 'hE7, 'hE7, 'hBF, 'hFF, 8, 0, 1);
	add_row(act_variant, 'h0E, 'h01, 0, 'hED, 'hAB, 'hBE, 'hFF, 5, 1, 0);
	add_row(act_joy, 'h118, 'h442, 0, 'h56, 'h57, 'h4F, 'hFF, 5, 1, 0);
	add_row(act_variant, 'h04, 'h02, 0, 'h56, 'h57, 'h4F, 'hFF, 5, 1, 0);  // Wrong index
	add_row(act_variant, 'h07, 'h01, 0, 'h56, 'h57, 'hEF, 'hFF, 0, 0, 0);  // Unknown code

	// ==============================
	// DIP bank
	// ==============================
	add_row(act_dip, 'hF0, 'hFE, 'h0000, 'h50, 'h57, 'hEF, 'hFF, 0, 0, 0);
	add_row(act_dip, 'h0F, 'hFE, 'h0003, 'h50, 'h57, 'hEF, 'h0F, 0, 0, 0);
	add_row(act_dip, 'h00, 'hFE, 'h0004, 'h50, 'h57, 'hEF, 'h0F, 0, 0, 0);
	add_row(act_dip, 'h00, 'hFD, 'h0001, 'h50, 'h57, 'hEF, 'h0F, 0, 0, 0);
	add_row(act_dip, 'h3C, 'hFE, 'h0001, 'h50, 'h14, 'hEF, 'h0F, 0, 0, 0);
	add_row(act_dip, 'h81, 'hFE, 'h0002, 'h50, 'h14, 'h81, 'h0F, 0, 0, 0);
	add_row(act_dip, 'h00, 'hFE, 'h0100, 'h50, 'h14, 'h81, 'h0F, 0, 0, 0);
	add_row(act_dip, 'hFF, 'hFE, 'h0000, 'h56, 'h14, 'h81, 'h0F, 0, 0, 0);
endtask

`endif

//--- dv/tb_input_top.sv
/*
  Testbench for the player input path, rows come from tb_vectors.svh
  Results are checked after the fixed latencies of the top level
*/
module tb_input_top;
	import arcade_input_pkg::*;

	localparam int CLK_HALF = 5;
	localparam int MAX_ROWS = 64;

	typedef enum logic [2:0] {
		act_idle,
		act_key,       // op_a {press, code}
		act_joy,       // op_a joy1, op_b joy2, op_c[0] alt_controls
		act_rand,      // LFSR joysticks, op_c holds the keys still pressed
		act_variant,   // op_a code, op_b index
		act_dip        // op_a data, op_b index, op_c address
	} action_e;

	typedef struct packed {
		action_e     act;
		logic [31:0] op_a;
		logic [31:0] op_b;
		logic [15:0] op_c;
		port_byte_t  exp_a;
		port_byte_t  exp_b;
		port_byte_t  exp_c;
		port_byte_t  exp_d;
		hw_sel_t     exp_hw;
		logic        exp_land;
		logic        exp_four;
	} row_t;

	logic        clk_sys;
	logic        rst_n;
	logic [10:0] ps2_key;
	joy_word_t   joy1;
	joy_word_t   joy2;
	logic        alt_controls;
	logic        dl_wr;
	logic [7:0]  dl_index;
	logic [15:0] dl_addr;
	logic [7:0]  dl_data;
	port_byte_t  port_a;
	port_byte_t  port_b;
	port_byte_t  port_c;
	port_byte_t  port_d;
	hw_sel_t     hw_sel;
	logic        landscape;
	logic        four_fire;

	row_t        rows [MAX_ROWS];
	int          n_rows;
	int          row_err;
	int          fail_rows;
	int          mismatches;
	int          cycle_cnt = 0;
	logic        timed_out;
	logic [31:0] lfsr;

	input_top i_dut (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.ps2_key      (ps2_key),
		.joy1         (joy1),
		.joy2         (joy2),
		.alt_controls (alt_controls),
		.dl_wr        (dl_wr),
		.dl_index     (dl_index),
		.dl_addr      (dl_addr),
		.dl_data      (dl_data),
		.port_a       (port_a),
		.port_b       (port_b),
		.port_c       (port_c),
		.port_d       (port_d),
		.hw_sel       (hw_sel),
		.landscape    (landscape),
		.four_fire    (four_fire)
	);

	initial
	begin
		clk_sys = 1'b0;
		forever #CLK_HALF clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys)
		cycle_cnt <= cycle_cnt + 1;

	// ==============================
	// Helpers
	// ==============================

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_word(output joy_word_t w);
		int i;
		w = '0;
		for (i = 0; i < 32; i++)
		begin
			lfsr = lfsr_next(lfsr);
			w    = {w[30:0], lfsr[0]};   // One step per bit
		end
	endtask

	// Scramble bytes from the mapping rules, bit 7 first
	function automatic logic [31:0] scramble_ports(input key_btn_t k, input joy_word_t j1,
			input joy_word_t j2);
		joy_word_t j;
		logic      up;
		logic      down;
		logic      left;
		logic      right;
		logic      fa;
		logic      fb;
		logic      s1;
		logic      s2;
		logic      coin;
		j     = j1 | j2;
		up    = k[kb_up] | k[kb_up2] | j[3];
		down  = k[kb_down] | k[kb_down2] | j[2];
		left  = k[kb_left] | k[kb_left2] | j[1];
		right = k[kb_right] | k[kb_right2] | j[0];
		fa    = k[kb_fire1] | k[kb_fire1_2] | j[4];
		fb    = k[kb_fire2] | k[kb_fire2_2] | j[5];
		s1    = k[kb_start1] | j[8];
		s2    = k[kb_start2] | j[9];
		coin  = k[kb_coin1] | k[kb_coin2] | j[10];
		return {~{coin, 1'b0, left, right, fa, 1'b0, fb, up},
			~{s1, s2, left, right, fa, fb, 2'b00},
			~{1'b0, down, 1'b0, up, 3'b000, down}, 8'hFF};
	endfunction

	task automatic add_row(input action_e act, input logic [31:0] a, input logic [31:0] b,
			input logic [15:0] c, input port_byte_t ea, input port_byte_t eb,
			input port_byte_t ec, input port_byte_t ed, input hw_sel_t hw,
			input logic land, input logic four);
		rows[n_rows] = '{act, a, b, c, ea, eb, ec, ed, hw, land, four};
		n_rows++;
	endtask

	`include "tb_vectors.svh"

	// Waits n rising edges, returns one unit after the last one
	task automatic wait_cycles(input int n);
		int target;
		int waited;
		target = cycle_cnt + n;
		waited = 0;
		while ((cycle_cnt < target) && (waited < (n + 2) * 2 * CLK_HALF))
		begin
			#1;
			waited++;
		end
		if (cycle_cnt < target)
		begin
			$display("Timeout: the clock stalled before %0d cycles had passed", n);
			timed_out = 1'b1;
		end
	endtask

	task automatic check_port(input string name, input port_byte_t got, input port_byte_t exp);
		if (got !== exp)
		begin
			$display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
			row_err++;
		end
	endtask

	task automatic check_hw_sel(input hw_sel_t got, input hw_sel_t exp);
		if (got !== exp)
		begin
			$display("MISMATCH hw_sel: got 0x%h expected 0x%h", got, exp);
			row_err++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
			row_err++;
		end
	endtask

	// ==============================
	// Row driver
	// ==============================
	task automatic apply_row(input row_t r);
		joy_word_t jr1;
		joy_word_t jr2;
		case (r.act)
			act_key:
			begin
				ps2_key = {~ps2_key[10], r.op_a[9:0]};   // New event
				wait_cycles(3);
			end
			act_joy:
			begin
				joy1         = r.op_a;
				joy2         = r.op_b;
				alt_controls = r.op_c[0];
				wait_cycles(2);
			end
			act_rand:
			begin
				rand_word(jr1);
				rand_word(jr2);
				joy1 = jr1;
				joy2 = jr2;
				{r.exp_a, r.exp_b, r.exp_c, r.exp_d} = scramble_ports(r.op_c, jr1, jr2);
				wait_cycles(2);
			end
			act_variant, act_dip:
			begin
				dl_wr    = 1'b1;
				dl_index = r.op_b[7:0];
				dl_addr  = r.op_c;
				dl_data  = r.op_a[7:0];
				wait_cycles(1);
				dl_wr = 1'b0;
				wait_cycles((r.act == act_variant) ? 2 : 1);
			end
			default:
				wait_cycles(1);
		endcase
		if (!timed_out)
		begin
			check_port("port_a", port_a, r.exp_a);
			check_port("port_b", port_b, r.exp_b);
			check_port("port_c", port_c, r.exp_c);
			check_port("port_d", port_d, r.exp_d);
			check_hw_sel(hw_sel, r.exp_hw);
			check_flag("landscape", landscape, r.exp_land);
			check_flag("four_fire", four_fire, r.exp_four);
		end
	endtask

	// ==============================
	// Main sequence
	// ==============================
	initial
	begin
		int i;
		lfsr         = 32'hbff2;
		timed_out    = 1'b0;
		n_rows       = 0;
		fail_rows    = 0;
		mismatches   = 0;
		rst_n        = 1'b0;
		ps2_key      = '0;
		joy1         = '0;
		joy2         = '0;
		alt_controls = 1'b0;
		dl_wr        = 1'b0;
		dl_index     = '0;
		dl_addr      = '0;
		dl_data      = '0;
		load_vectors();
		wait_cycles(3);
		rst_n = 1'b1;

		for (i = 0; (i < n_rows) && !timed_out; i++)
		begin
			row_err = 0;
			apply_row(rows[i]);
			mismatches += row_err;
			if (timed_out)
			begin
				$display("row %0d %s: stopped by a timeout", i, rows[i].act.name());
				fail_rows++;
			end
			else if (row_err == 0)
				$display("row %0d %s: ok", i, rows[i].act.name());
			else
			begin
				$display("row %0d %s: %0d mismatches", i, rows[i].act.name(), row_err);
				fail_rows++;
			end
		end

		$display("Rows run: %0d of %0d, failed: %0d, mismatches: %0d", i, n_rows, fail_rows,
			mismatches);
		if ((fail_rows == 0) && !timed_out)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+dv
source/arcade_input_pkg.sv
source/kbd_decode.sv
source/game_select.sv
source/port_mapper.sv
source/dip_mask.sv
source/input_top.sv
dv/tb_input_top.sv
